//--- game_control_unit.sv
// Moore FSM of the memory game control unit for playback, play, compare and game end
`timescale 1ns/100ps

module game_control_unit import memory_game_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        start,
    input  logic        level,
    input  logic        last_move,
    input  logic        move_matches,
    input  logic        round_done,
    input  logic        has_move,
    input  logic        response_timeout,
    input  logic        led_timeout,
    output logic        clear_move,
    output logic        count_move,
    output logic        clear_limit,
    output logic        count_limit,
    output logic        clear_play,
    output logic        store_play,
    output logic        count_response,
    output logic        clear_response,
    output logic        count_led,
    output logic        clear_led,
    output logic        show_leds,
    output logic        level_hard,
    output logic        ready,
    output logic        won,
    output logic        lost,
    output logic        timed_out,
    output state_code_t state_code
);

    game_state_t state, next_state;

    // ------------------------------------------------------------
    // State register
    // ------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            state <= s_idle;
        else
            state <= next_state;
    end

    // Level is sampled once per game
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            level_hard <= 1'b0;
        else if (state == s_prepare)
            level_hard <= level;
    end

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            s_idle:         if (start) next_state = s_prepare;
            s_prepare:      next_state = s_show_led;
            s_next_round:   next_state = s_show_led;

            // Playback loop
            s_show_led: begin
                if (led_timeout)
                    next_state = round_done ? s_start_play : s_led_shown;
            end
            s_led_shown:    next_state = s_led_gap;
            s_led_gap:      if (led_timeout) next_state = s_gap_done;
            s_gap_done:     next_state = s_show_led;

            // Player's turn
            s_start_play:   next_state = s_wait_move;
            s_wait_move: begin
                if (response_timeout)
                    next_state = s_lost_timeout;
                else if (has_move)
                    next_state = s_store_move;
            end
            s_store_move:   next_state = s_compare;
            s_compare: begin
                if (!move_matches)
                    next_state = s_lost_error;
                else if (last_move)
                    next_state = s_won;
                else if (round_done)
                    next_state = s_next_round;
                else
                    next_state = s_next_move;
            end
            s_next_move:    next_state = s_wait_move;

            // End states wait for a new game
            s_won,
            s_lost_error,
            s_lost_timeout: if (start) next_state = s_prepare;

            default:        next_state = s_idle;
        endcase
    end

    // ------------------------------------------------------------
    // Moore outputs
    // ------------------------------------------------------------
    assign clear_move     = (state == s_prepare) || (state == s_next_round)
                         || (state == s_start_play);
    assign count_move     = (state == s_led_shown) || (state == s_next_move);

    assign clear_limit    = (state == s_prepare);
    assign count_limit    = (state == s_next_round);

    assign clear_play     = (state == s_idle);
    assign store_play     = (state == s_store_move);

    assign clear_response = (state == s_prepare) || (state == s_next_round)
                         || (state == s_start_play) || (state == s_next_move);
    assign count_response = (state == s_wait_move);

    // LED timer restarts before each lit period and each gap
    assign clear_led      = (state == s_prepare) || (state == s_led_shown)
                         || (state == s_gap_done) || (state == s_start_play);
    assign count_led      = (state == s_show_led) || (state == s_led_gap);
    assign show_leds      = (state == s_show_led);

    assign ready          = (state == s_won) || (state == s_lost_error)
                         || (state == s_lost_timeout);
    assign won            = (state == s_won);
    assign lost           = (state == s_lost_error) || (state == s_lost_timeout);
    assign timed_out      = (state == s_lost_timeout);

    assign state_code     = state_code_t'(state);   // Enum codes are the debug codes

    assert property (@(posedge clock) disable iff (reset) !(won && lost));

endmodule

//--- game_datapath.sv
// Memory game datapath: counters, move register, button edge, timers, comparators
`timescale 1ns/100ps

`include "memory_game_params.svh"

module game_datapath import memory_game_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  move_t buttons,
    input  logic  level_hard,
    input  logic  clear_move,
    input  logic  count_move,
    input  logic  clear_limit,
    input  logic  count_limit,
    input  logic  clear_play,
    input  logic  store_play,
    input  logic  count_response,
    input  logic  clear_response,
    input  logic  count_led,
    input  logic  clear_led,
    input  logic  show_leds,
    output logic  last_move,
    output logic  move_matches,
    output logic  round_done,
    output logic  has_move,
    output logic  response_timeout,
    output logic  led_timeout,
    output move_t leds
);

    address_t                move_address;
    address_t                limit;
    address_t                last_address;
    move_t                   play_move;
    move_t                   rom_move;
    logic                    any_button_q;   // Previous OR of buttons
    logic [`MG_TIMER_W-1:0]  response_count;
    logic [`MG_TIMER_W-1:0]  led_count;
    logic [`MG_TIMER_W-1:0]  led_bound;

    // ------------------------------------------------------------
    // Address and limit counters
    // ------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            move_address <= '0;
        else if (clear_move)
            move_address <= '0;
        else if (count_move)
            move_address <= move_address + 1'b1;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            limit <= '0;
        else if (clear_limit)
            limit <= '0;
        else if (count_limit)
            limit <= limit + 1'b1;
    end

    // Player move register
    always_ff @(posedge clock) begin
        if (clear_play)
            play_move <= '0;
        else if (store_play)
            play_move <= buttons;
    end

    // Edge detect runs in every state, so a held button counts once
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            any_button_q <= 1'b0;
        else
            any_button_q <= |buttons;
    end

    assign has_move = (|buttons) & ~any_button_q;

    // ------------------------------------------------------------
    // Timers
    // ------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            response_count <= '0;
        else if (clear_response)
            response_count <= '0;
        else if (count_response)
            response_count <= response_count + 1'b1;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            led_count <= '0;
        else if (clear_led)
            led_count <= '0;
        else if (count_led)
            led_count <= led_count + 1'b1;
    end

    // Lit period while showing, dark gap otherwise
    assign led_bound = show_leds ? `MG_TIMER_W'(`MG_LED_ON_CYCLES)
                                 : `MG_TIMER_W'(`MG_LED_GAP_CYCLES);

    assign led_timeout      = (led_count == led_bound);
    assign response_timeout = (response_count == `MG_TIMER_W'(`MG_RESPONSE_CYCLES));

    // ------------------------------------------------------------
    // Sequence lookup and comparators
    // ------------------------------------------------------------
    sequence_rom rom (
        .address (move_address),
        .move    (rom_move)
    );

    assign last_address = level_hard ? `MG_ADDR_W'(`MG_HARD_LAST)
                                     : `MG_ADDR_W'(`MG_EASY_LAST);

    assign last_move    = (move_address == last_address);
    assign round_done   = (move_address == limit);
    assign move_matches = (play_move == rom_move);
    assign leds         = show_leds ? rom_move : '0;

    // Control unit never stores a move while stepping the address
    assert property (@(posedge clock) disable iff (reset)
        !(store_play && count_move));

endmodule

//--- memory_game.sv
// Memory game top level joining control unit and datapath
`timescale 1ns/100ps

module memory_game import memory_game_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        start,
    input  logic        level,
    input  move_t       buttons,
    output move_t       leds,
    output logic        ready,
    output logic        won,
    output logic        lost,
    output logic        timed_out,
    output state_code_t state_code
);

    // Control strobes
    logic clear_move, count_move;
    logic clear_limit, count_limit;
    logic clear_play, store_play;
    logic count_response, clear_response;
    logic count_led, clear_led;
    logic show_leds;
    logic level_hard;

    // Datapath status
    logic last_move, move_matches, round_done;
    logic has_move, response_timeout, led_timeout;

    game_control_unit control (
        .clock            (clock),
        .reset            (reset),
        .start            (start),
        .level            (level),
        .last_move        (last_move),
        .move_matches     (move_matches),
        .round_done       (round_done),
        .has_move         (has_move),
        .response_timeout (response_timeout),
        .led_timeout      (led_timeout),
        .clear_move       (clear_move),
        .count_move       (count_move),
        .clear_limit      (clear_limit),
        .count_limit      (count_limit),
        .clear_play       (clear_play),
        .store_play       (store_play),
        .count_response   (count_response),
        .clear_response   (clear_response),
        .count_led        (count_led),
        .clear_led        (clear_led),
        .show_leds        (show_leds),
        .level_hard       (level_hard),
        .ready            (ready),
        .won              (won),
        .lost             (lost),
        .timed_out        (timed_out),
        .state_code       (state_code)
    );

    game_datapath datapath (
        .clock            (clock),
        .reset            (reset),
        .buttons          (buttons),
        .level_hard       (level_hard),
        .clear_move       (clear_move),
        .count_move       (count_move),
        .clear_limit      (clear_limit),
        .count_limit      (count_limit),
        .clear_play       (clear_play),
        .store_play       (store_play),
        .count_response   (count_response),
        .clear_response   (clear_response),
        .count_led        (count_led),
        .clear_led        (clear_led),
        .show_leds        (show_leds),
        .last_move        (last_move),
        .move_matches     (move_matches),
        .round_done       (round_done),
        .has_move         (has_move),
        .response_timeout (response_timeout),
        .led_timeout      (led_timeout),
        .leds             (leds)
    );

endmodule

//--- memory_game_params.svh
// Memory game widths, level end addresses and timer lengths
`ifndef MEMORY_GAME_PARAMS_SVH
`define MEMORY_GAME_PARAMS_SVH

// ------------------------------------------------------------
// Sequence memory
// ------------------------------------------------------------
`define MG_ADDR_W           4
`define MG_MEM_DEPTH        16    // 2**MG_ADDR_W entries
`define MG_EASY_LAST        7     // Level 0 ends here
`define MG_HARD_LAST        15    // Level 1 ends here

// ------------------------------------------------------------
// Timers, in clock cycles
// ------------------------------------------------------------
`define MG_TIMER_W          8
`define MG_LED_ON_CYCLES    6     // Lit period of one move
`define MG_LED_GAP_CYCLES   3     // Dark gap after a move
`define MG_RESPONSE_CYCLES  48    // Time allowed per player move

`endif

//--- memory_game_pkg.sv
// Memory game types: address, move, state code and the control state enum
package memory_game_pkg;

    `include "memory_game_params.svh"

    typedef logic [`MG_ADDR_W-1:0] address_t;
    typedef logic [3:0]            move_t;        // One-hot, one bit per LED/button
    typedef logic [3:0]            state_code_t;

    // Encodings double as the debug state code
    typedef enum state_code_t {
        s_idle         = 4'h0,
        s_prepare      = 4'h1,
        s_next_round   = 4'h2,
        s_wait_move    = 4'h3,
        s_store_move   = 4'h4,
        s_compare      = 4'h5,
        s_next_move    = 4'h6,
        s_led_gap      = 4'h7,
        s_gap_done     = 4'h8,
        s_won          = 4'hA,
        s_show_led     = 4'hB,
        s_led_shown    = 4'hC,
        s_start_play   = 4'hD,
        s_lost_error   = 4'hE,
        s_lost_timeout = 4'hF
    } game_state_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -f vlog.f --top-module tb_memory_game -o sim_memory_game \
    && ./obj_dir/sim_memory_game | grep -q "TEST PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sequence_rom.sv
// Fixed move sequence ROM with asynchronous read
`timescale 1ns/100ps

`include "memory_game_params.svh"

module sequence_rom import memory_game_pkg::*; (
    input  address_t address,
    output move_t    move
);

    // Entry i lights LED ((3*i + i/4) mod 4)
    localparam move_t rom_table [`MG_MEM_DEPTH] = '{
        4'b0001, 4'b1000, 4'b0100, 4'b0010,    // 0..3
        4'b0010, 4'b0001, 4'b1000, 4'b0100,    // 4..7
        4'b0100, 4'b0010, 4'b0001, 4'b1000,    // 8..11
        4'b1000, 4'b0100, 4'b0010, 4'b0001     // 12..15
    };

    assign move = rom_table[address];

endmodule

//--- tb_memory_game.sv
// Testbench for the memory game: clock, LFSR stimulus, game model, compare tasks, watchdog
`timescale 1ns/100ps

`include "memory_game_params.svh"

module tb_memory_game import memory_game_pkg::*;;

    // Two hard games with full playback take well under 8000 cycles
    localparam int max_cycles = 40000;

    logic        clock;
    logic        reset;
    logic        start;
    logic        level;
    move_t       buttons;
    move_t       leds;
    logic        ready;
    logic        won;
    logic        lost;
    logic        timed_out;
    state_code_t state_code;

    logic [31:0] lfsr_state;
    int          cycle_count;
    int          check_count;
    int          error_count;
    int          test_count;
    int          failed_tests;

    memory_game uut (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .level      (level),
        .buttons    (buttons),
        .leds       (leds),
        .ready      (ready),
        .won        (won),
        .lost       (lost),
        .timed_out  (timed_out),
        .state_code (state_code)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Watchdog
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count == max_cycles) begin
            $display("run stopped after %0d cycles without finishing", max_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Random numbers and game model
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // Taps 32,22,2,1
    endfunction

    task automatic take_bits(input int n, output int value);
        int i;
        value = 0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = value * 2 + int'(lfsr_state[0]);
        end
    endtask

    function automatic move_t rom_entry(input int i);
        return move_t'(4'b0001 << ((i * 3 + i / 4) % 4));
    endfunction

    // Rotate the right button left by 1 to 3 places
    function automatic move_t wrong_button(input move_t right, input int shift);
        logic [7:0] wide;
        wide = {4'b0000, right} << shift;
        return wide[3:0] | wide[7:4];
    endfunction

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_move(input string name, input move_t got, input move_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_state(input string name, input state_code_t got,
                               input state_code_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_outcome(input logic [3:0] got, input logic [3:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] {ready,won,lost,timed_out}: got %h, expected %h", got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before)
            $display("%-28s ok", name);
        else begin
            failed_tests++;
            $display("%-28s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // ------------------------------------------------------------
    // Player
    // ------------------------------------------------------------
    task automatic drive_slot();
        @(posedge clock);
        #2;
    endtask

    // Checks leds in every show_led until wait_move or an end state
    task automatic follow_playback(output int visits, output state_code_t code);
        state_code_t prev;
        visits = 0;
        prev = state_code;
        while (1) begin
            @(negedge clock);
            code = state_code;
            if (code == 4'hB) begin
                if (prev != 4'hB)
                    visits++;
                check_move("leds", leds, rom_entry(visits - 1));
            end
            prev = code;
            if (code == 4'h3 || code == 4'hA || code == 4'hE || code == 4'hF)
                break;
        end
    endtask

    task automatic wait_for_end(output state_code_t code);
        do begin
            @(negedge clock);
            code = state_code;
        end while (code != 4'hA && code != 4'hE && code != 4'hF);
    endtask

    task automatic press_button(input move_t press, input int delay);
        repeat (delay) drive_slot();
        buttons = press;
        drive_slot();
        drive_slot();
        buttons = '0;
    endtask

    // Rounds given as -1 are played without error or silence
    task automatic play_game(input logic hard, input int error_round, input int quiet_round,
                             output state_code_t code, output int rounds_done);
        int r;
        int m;
        int visits;
        int delay;
        int shift;
        move_t press;
        r = 0;
        m = 0;
        rounds_done = 0;
        drive_slot();
        level = hard;
        start = 1'b1;
        drive_slot();
        start = 1'b0;
        while (1) begin
            follow_playback(visits, code);
            if (code == 4'h3 && visits != (m == 0 ? r + 1 : 0)) begin
                error_count++;
                $display("round %0d move %0d: %0d moves played back, expected %0d",
                         r, m, visits, m == 0 ? r + 1 : 0);
            end
            if (code != 4'h3)
                break;
            if (r == quiet_round) begin
                wait_for_end(code);
                break;
            end
            press = rom_entry(m);
            if (r == error_round && m == r) begin
                take_bits(2, shift);
                press = wrong_button(press, shift % 3 + 1);
            end
            take_bits(4, delay);
            press_button(press, delay % 10 + 1);
            m++;
            if (m > r) begin
                rounds_done = r + 1;
                r++;
                m = 0;
            end
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        state_code_t code;
        int          rounds;
        int          errors_before;
        int          value;
        logic        hard;
        lfsr_state   = 32'h8a9e21d6;
        cycle_count  = 0;
        check_count  = 0;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        reset   = 1'b1;
        start   = 1'b0;
        level   = 1'b0;
        buttons = '0;
        repeat (4) @(posedge clock);
        #2 reset = 1'b0;

        errors_before = error_count;
        @(negedge clock);
        check_state("state_code", state_code, 4'h0);
        check_move("leds", leds, '0);
        check_outcome({ready, won, lost, timed_out}, 4'b0000);
        report_test("reset", errors_before);

        errors_before = error_count;
        play_game(1'b0, -1, -1, code, rounds);
        check_state("state_code", code, 4'hA);
        check_outcome({ready, won, lost, timed_out}, 4'b1100);
        if (rounds != `MG_EASY_LAST + 1) begin
            error_count++;
            $display("easy game won after %0d rounds instead of %0d", rounds, `MG_EASY_LAST + 1);
        end
        report_test("level 0 win", errors_before);

        errors_before = error_count;
        play_game(1'b1, -1, -1, code, rounds);
        check_state("state_code", code, 4'hA);
        check_outcome({ready, won, lost, timed_out}, 4'b1100);
        if (rounds != `MG_HARD_LAST + 1) begin
            error_count++;
            $display("hard game won after %0d rounds instead of %0d", rounds, `MG_HARD_LAST + 1);
        end
        report_test("level 1 win", errors_before);

        errors_before = error_count;
        take_bits(1, value);
        hard = value[0];
        take_bits(4, value);
        value = value % ((hard ? `MG_HARD_LAST : `MG_EASY_LAST) + 1);
        play_game(hard, value, -1, code, rounds);
        check_state("state_code", code, 4'hE);
        check_outcome({ready, won, lost, timed_out}, 4'b1010);
        report_test("wrong button", errors_before);

        errors_before = error_count;
        take_bits(1, value);
        hard = value[0];
        take_bits(2, value);
        play_game(hard, -1, value, code, rounds);
        check_state("state_code", code, 4'hF);
        check_outcome({ready, won, lost, timed_out}, 4'b1011);
        drive_slot();
        start = 1'b1;
        drive_slot();
        start = 1'b0;
        @(negedge clock);
        check_state("state_code", state_code, 4'h1);    // New game enters prepare
        report_test("response timeout", errors_before);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
memory_game_pkg.sv
sequence_rom.sv
game_datapath.sv
game_control_unit.sv
memory_game.sv
tb_memory_game.sv
